/* include/pf_consts.svh */
`ifndef PF_CONSTS_SVH
`define PF_CONSTS_SVH

`define PF_ADDR_W           16          // vram word address bits
`define PF_WORD_W           16          // vram data bits
`define PF_COLOR_W          8           // pixel index bits
`define PF_HCOUNT_W         11          // horizontal pixel count bits

`define PF_SCANOUT_BEGIN    160         // h count one cycle before first displayed pixel
`define PF_SCANOUT_END      800         // h count where scanout stops

`define PF_REG_W            3           // register number bits
`define PF_REG_START        3'd0        // display start address
`define PF_REG_LINE_LEN     3'd1        // words per line
`define PF_REG_GFX_CTRL     3'd2        // blank, bpp, h/v repeat
`define PF_REG_COLORBASE    3'd3        // xor'd onto every pixel index
`define PF_REG_BORDER       3'd4        // color outside the scanout window
`define PF_REG_LINE_START   3'd5        // next line start override

`define PF_GFX_BLANK_BIT    7           // 1 = playfield off
`define PF_GFX_BPP_BIT      4           // 0 = 4 bpp, 1 = 8 bpp
`define PF_GFX_HREP_LSB     2           // 2-bit horizontal repeat
`define PF_GFX_VREP_LSB     0           // 2-bit vertical repeat

`endif

/* rtl/pf_pkg.sv */
`include "pf_consts.svh"

package pf_pkg;

    typedef logic [`PF_ADDR_W-1:0]   addr_t;        // vram word address
    typedef logic [`PF_WORD_W-1:0]   word_t;        // vram data word
    typedef logic [`PF_COLOR_W-1:0]  color_t;       // pixel color index
    typedef logic [`PF_HCOUNT_W-1:0] hcount_t;      // horizontal pixel count

    // extra cycles (or lines) a pixel is repeated, 0 = shown once
    typedef logic [1:0] rep_t;

    typedef enum logic {
        BPP_4 = 1'b0,                               // one nibble per pixel, 2 words per group
        BPP_8 = 1'b1                                // one byte per pixel
    } bpp_e;

    // one group of 8 pixels, element 7 (top byte) is shown first
    typedef color_t [7:0] pixels_t;

endpackage

/* rtl/pf_regs.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module pf_regs import pf_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    reg_wr_i,               // register write strobe
    input  logic [`PF_REG_W-1:0]    reg_num_i,              // register being written
    input  word_t                   reg_data_i,
    output addr_t                   start_addr_o,           // frame start address
    output word_t                   line_len_o,             // words added per line
    output logic                    blank_o,
    output bpp_e                    bpp_o,
    output rep_t                    h_rep_o,
    output rep_t                    v_rep_o,
    output color_t                  colorbase_o,
    output color_t                  border_o,
    output logic                    gfx_ctrl_set_o,         // pulse, gfx ctrl just written
    output logic                    line_start_set_o,       // pulse, line start override written
    output addr_t                   line_start_addr_o       // override address
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_addr_o      <= '0;
            line_len_o        <= '0;
            blank_o           <= 1'b0;
            bpp_o             <= BPP_4;
            h_rep_o           <= '0;
            v_rep_o           <= '0;
            colorbase_o       <= '0;
            border_o          <= '0;
            gfx_ctrl_set_o    <= 1'b0;
            line_start_set_o  <= 1'b0;
            line_start_addr_o <= '0;
        end else begin
            gfx_ctrl_set_o   <= 1'b0;                       // pulses last one cycle
            line_start_set_o <= 1'b0;
            if (reg_wr_i) begin
                case (reg_num_i)
                    `PF_REG_START:      start_addr_o <= reg_data_i;
                    `PF_REG_LINE_LEN:   line_len_o   <= reg_data_i;
                    `PF_REG_GFX_CTRL: begin                 // unpack control word fields
                        blank_o        <= reg_data_i[`PF_GFX_BLANK_BIT];
                        bpp_o          <= bpp_e'(reg_data_i[`PF_GFX_BPP_BIT]);
                        h_rep_o        <= reg_data_i[`PF_GFX_HREP_LSB +: 2];
                        v_rep_o        <= reg_data_i[`PF_GFX_VREP_LSB +: 2];
                        gfx_ctrl_set_o <= 1'b1;             // line addr reloads v countdown
                    end
                    `PF_REG_COLORBASE:  colorbase_o  <= reg_data_i[`PF_COLOR_W-1:0];
                    `PF_REG_BORDER:     border_o     <= reg_data_i[`PF_COLOR_W-1:0];
                    `PF_REG_LINE_START: begin
                        line_start_addr_o <= reg_data_i;
                        line_start_set_o  <= 1'b1;          // takes over at once
                    end
                    default: ;                              // 6 and 7 unused
                endcase
            end
        end
    end

endmodule

/* rtl/pf_line_addr.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module pf_line_addr import pf_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    end_of_line_i,
    input  logic    end_of_frame_i,
    input  logic    blank_i,
    input  addr_t   start_addr_i,                           // frame start address
    input  word_t   line_len_i,
    input  rep_t    v_rep_i,                                // extra repeats of each line
    input  logic    gfx_ctrl_set_i,
    input  logic    line_start_set_i,
    input  addr_t   line_start_addr_i,
    output addr_t   line_start_o                            // first word of the current line
);

    rep_t v_count;                                          // repeats left before advancing

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start_o <= '0;
            v_count      <= '0;
        end else begin
            if (gfx_ctrl_set_i) begin
                v_count <= v_rep_i;                         // new repeat takes effect now
            end
            if (line_start_set_i) begin
                line_start_o <= line_start_addr_i;          // software override
            end
            if (end_of_line_i) begin
                if (v_count != '0) begin
                    v_count <= v_count - 1'b1;              // show same line again
                end else begin
                    v_count      <= v_rep_i;
                    line_start_o <= line_start_o + `PF_ADDR_W'(line_len_i);
                end
            end
            // a new frame, or a blanked plane, starts over from the top
            if (blank_i || end_of_frame_i) begin
                line_start_o <= start_addr_i;
                v_count      <= v_rep_i;
            end
        end
    end

endmodule

/* rtl/pf_fetch.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module pf_fetch import pf_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        mem_fetch_i,        // fetch window
    input  logic                        mem_fetch_start_i,  // start of fetch window
    input  addr_t                       line_start_i,
    input  bpp_e                        bpp_i,
    input  logic                        buf_full_i,         // pixel buffer still occupied
    input  word_t                       vram_data_i,        // valid one cycle after select
    output logic                        vram_sel_o,
    output addr_t                       vram_addr_o,
    output logic                        words_ready_o,      // pulse, words_o hold a group
    output logic [4*`PF_WORD_W-1:0]     words_o             // word 0 in the top bits
);

    typedef enum logic [2:0] {
        FETCH_IDLE,                                         // outside the fetch window
        FETCH_ADDR,                                         // first select, waits for buffer room
        FETCH_WAIT,                                         // second select, hand over last group
        FETCH_READ_0,                                       // capture word 0 (8 bpp: 3rd select)
        FETCH_READ_1,                                       // capture word 1 (8 bpp: 4th select)
        FETCH_READ_2,
        FETCH_READ_3
    } fetch_st_e;

    fetch_st_e  state;
    addr_t      disp_addr;                                  // next display word to read
    logic       initial_grp;                                // no complete group yet this line
    logic       issue;                                      // select a word this cycle

    // 4 bpp needs two words per group, 8 bpp needs four
    always_comb begin
        issue = 1'b0;
        if (mem_fetch_i) begin
            case (state)
                FETCH_ADDR:   issue = !buf_full_i;
                FETCH_WAIT:   issue = 1'b1;
                FETCH_READ_0: issue = (bpp_i == BPP_8);
                FETCH_READ_1: issue = (bpp_i == BPP_8);
                default:      issue = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            disp_addr     <= '0;
            initial_grp   <= 1'b0;
            vram_sel_o    <= 1'b0;
            vram_addr_o   <= '0;
            words_ready_o <= 1'b0;
        end else begin
            vram_sel_o    <= issue;
            words_ready_o <= 1'b0;
            if (issue) begin
                vram_addr_o <= disp_addr;
                disp_addr   <= disp_addr + 1'b1;
            end
            if (!mem_fetch_i) begin
                state <= FETCH_IDLE;                        // window closed, drop partial group
            end else begin
                case (state)
                    FETCH_IDLE: state <= FETCH_ADDR;
                    FETCH_ADDR: begin
                        if (!buf_full_i) begin
                            state <= FETCH_WAIT;
                        end
                    end
                    FETCH_WAIT: begin
                        words_ready_o <= !initial_grp;      // words_o hold the previous group
                        initial_grp   <= 1'b0;
                        state         <= FETCH_READ_0;
                    end
                    FETCH_READ_0: state <= FETCH_READ_1;
                    FETCH_READ_1: state <= (bpp_i == BPP_8) ? FETCH_READ_2 : FETCH_ADDR;
                    FETCH_READ_2: state <= FETCH_READ_3;
                    default:      state <= FETCH_ADDR;      // READ_3 ends the group
                endcase
            end
            if (mem_fetch_start_i) begin
                disp_addr   <= line_start_i;                // rewind to this line's data
                initial_grp <= 1'b1;
            end
        end
    end

    // words are overwritten only after the buffer has copied them
    always_ff @(posedge clk) begin
        case (state)
            FETCH_READ_0: words_o[3*`PF_WORD_W +: `PF_WORD_W] <= vram_data_i;
            FETCH_READ_1: words_o[2*`PF_WORD_W +: `PF_WORD_W] <= vram_data_i;
            FETCH_READ_2: words_o[1*`PF_WORD_W +: `PF_WORD_W] <= vram_data_i;
            FETCH_READ_3: words_o[0 +: `PF_WORD_W]            <= vram_data_i;
            default: ;
        endcase
    end

endmodule

/* rtl/pf_pixel_buf.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module pf_pixel_buf import pf_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        mem_fetch_start_i,  // new line, drop old group
    input  bpp_e                        bpp_i,
    input  logic                        words_ready_i,
    input  logic [4*`PF_WORD_W-1:0]     words_i,
    input  logic                        buf_take_i,         // scanout copies pixels_o
    output logic                        buf_full_o,
    output pixels_t                     pixels_o
);

    pixels_t expanded;                                      // words_i as 8 indices

    // element 7 is the first pixel, taken from the top of words_i
    always_comb begin
        for (int j = 0; j < 8; j++) begin
            if (bpp_i == BPP_8) begin
                expanded[j] = words_i[j*`PF_COLOR_W +: `PF_COLOR_W];
            end else begin
                expanded[j] = {4'h0, words_i[2*`PF_WORD_W + 4*j +: 4]};    // words 0 and 1
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full_o <= 1'b0;
        end else begin
            if (buf_take_i || mem_fetch_start_i) begin
                buf_full_o <= 1'b0;                         // room for the next group
            end
            if (words_ready_i) begin
                buf_full_o <= 1'b1;                         // new group wins over a take
            end
        end
    end

    always_ff @(posedge clk) begin
        if (words_ready_i) begin
            pixels_o <= expanded;
        end
    end

endmodule

/* rtl/pf_scanout.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module pf_scanout import pf_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  hcount_t h_count_i,
    input  logic    mem_fetch_i,
    input  logic    mem_fetch_start_i,
    input  logic    end_of_line_i,
    input  logic    blank_i,
    input  rep_t    h_rep_i,                                // extra cycles per pixel
    input  color_t  colorbase_i,
    input  color_t  border_i,
    input  pixels_t pixels_i,                               // group waiting in the buffer
    output logic    buf_take_o,                             // pulse, group copied this cycle
    output color_t  color_o
);

    logic       scanout;                                    // inside the display window
    logic       scanout_start;
    logic       scanout_end;
    logic       next_pixel;                                 // current pixel fully shown
    rep_t       rep_count;                                  // cycles left on current pixel
    logic [2:0] column;                                     // pixel within the group
    pixels_t    shifter;                                    // element 7 is on screen

    always_comb begin
        scanout_start = mem_fetch_i && (h_count_i == hcount_t'(`PF_SCANOUT_BEGIN));
        scanout_end   = (h_count_i == hcount_t'(`PF_SCANOUT_END));
        next_pixel    = scanout && (rep_count == '0);
        buf_take_o    = scanout_start || (next_pixel && column == 3'd7);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout   <= 1'b0;
            rep_count <= '0;
            column    <= '0;
            color_o   <= '0;
        end else begin
            if (scanout_start) begin
                scanout   <= 1'b1;
                rep_count <= h_rep_i;
                column    <= '0;
            end else if (next_pixel) begin
                rep_count <= h_rep_i;                       // reload for the next pixel
                column    <= column + 1'b1;                 // wraps to 0 on group load
            end else if (scanout) begin
                rep_count <= rep_count - 1'b1;
            end
            if (scanout_end || end_of_line_i || mem_fetch_start_i) begin
                scanout <= 1'b0;
            end
            // border outside the window and while blanked
            color_o <= (scanout && !blank_i) ? (shifter[7] ^ colorbase_i) : border_i;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_take_o) begin
            shifter <= pixels_i;                            // next 8 pixels from buffer
        end else if (next_pixel) begin
            shifter <= {shifter[6:0], border_i};            // bring up next pixel
        end
    end

endmodule

/* rtl/video_playfield.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module video_playfield import pf_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  hcount_t                 h_count_i,
    input  logic                    mem_fetch_i,            // fetch window level
    input  logic                    mem_fetch_start_i,
    input  logic                    end_of_line_i,
    input  logic                    end_of_frame_i,
    input  logic                    reg_wr_i,
    input  logic [`PF_REG_W-1:0]    reg_num_i,
    input  word_t                   reg_data_i,
    output logic                    vram_sel_o,
    output addr_t                   vram_addr_o,
    input  word_t                   vram_data_i,            // one cycle after vram_sel_o
    output color_t                  color_o
);

    addr_t                      start_addr;
    addr_t                      line_start_addr;            // override from register write
    addr_t                      line_start;                 // current line start
    word_t                      line_len;
    logic                       blank;
    bpp_e                       bpp;
    rep_t                       h_rep;
    rep_t                       v_rep;
    color_t                     colorbase;
    color_t                     border;
    logic                       gfx_ctrl_set;
    logic                       line_start_set;
    logic                       fetch_en;                   // window with plane enabled
    logic                       words_ready;
    logic [4*`PF_WORD_W-1:0]    words;
    logic                       buf_full;
    logic                       buf_take;
    pixels_t                    pixels;

    assign fetch_en = mem_fetch_i && !blank;                // blanked plane reads nothing

    pf_regs u_regs (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i,
        .start_addr_o(start_addr), .line_len_o(line_len), .blank_o(blank),
        .bpp_o(bpp), .h_rep_o(h_rep), .v_rep_o(v_rep),
        .colorbase_o(colorbase), .border_o(border),
        .gfx_ctrl_set_o(gfx_ctrl_set), .line_start_set_o(line_start_set),
        .line_start_addr_o(line_start_addr)
    );

    pf_line_addr u_line_addr (
        .clk, .reset_i, .end_of_line_i, .end_of_frame_i,
        .blank_i(blank), .start_addr_i(start_addr), .line_len_i(line_len),
        .v_rep_i(v_rep), .gfx_ctrl_set_i(gfx_ctrl_set),
        .line_start_set_i(line_start_set), .line_start_addr_i(line_start_addr),
        .line_start_o(line_start)
    );

    pf_fetch u_fetch (
        .clk, .reset_i, .mem_fetch_i(fetch_en), .mem_fetch_start_i,
        .line_start_i(line_start), .bpp_i(bpp), .buf_full_i(buf_full),
        .vram_data_i, .vram_sel_o, .vram_addr_o,
        .words_ready_o(words_ready), .words_o(words)
    );

    pf_pixel_buf u_pixel_buf (
        .clk, .reset_i, .mem_fetch_start_i, .bpp_i(bpp),
        .words_ready_i(words_ready), .words_i(words), .buf_take_i(buf_take),
        .buf_full_o(buf_full), .pixels_o(pixels)
    );

    pf_scanout u_scanout (
        .clk, .reset_i, .h_count_i, .mem_fetch_i, .mem_fetch_start_i, .end_of_line_i,
        .blank_i(blank), .h_rep_i(h_rep), .colorbase_i(colorbase), .border_i(border),
        .pixels_i(pixels), .buf_take_o(buf_take), .color_o
    );

endmodule

/* verification/video_playfield_sva.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module video_playfield_sva import pf_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    mem_fetch_i,                            // raw fetch window
    input  logic    vram_sel_o,
    input  addr_t   vram_addr_o
);

    // select register clears on the reset edge
    sel_low_after_reset: assert property (@(posedge clk) reset_i |=> !vram_sel_o)
        else $error("vram_sel_o high in the cycle after reset");

    // selects come only from a recent fetch window
    sel_inside_window: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> ($past(mem_fetch_i, 1) || $past(mem_fetch_i, 2)))
        else $error("vram_sel_o high outside the fetch window");

    // back to back selects step through the display words
    sel_addr_step: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && $past(vram_sel_o) |-> vram_addr_o == addr_t'($past(vram_addr_o) + 1'b1))
        else $error("vram_addr_o did not advance by one within a group");

endmodule

bind video_playfield video_playfield_sva u_sva (
    .clk(clk),
    .reset_i(reset_i),
    .mem_fetch_i(mem_fetch_i),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o)
);

/* verification/tb_video_playfield.sv */
`timescale 1ns/100ps
`include "pf_consts.svh"

module tb_video_playfield import pf_pkg::*; ();

    localparam int LINE_H      = 900;                           // h counts per line
    localparam int FETCH_START = 100;                           // fetch window opens
    localparam int FETCH_STOP  = 850;                           // last h count of the window
    localparam int LINES       = 6;                             // lines per frame
    localparam int NUM_CASES   = 6;
    localparam int FIRST_PIX   = `PF_SCANOUT_BEGIN + 2;         // window opens, then color_o register
    localparam int LAST_PIX    = `PF_SCANOUT_END + 1;           // pixel at END still shown, one late

    typedef struct packed {
        addr_t  start;                                          // frame start address
        word_t  len;                                            // line length in words
        bpp_e   bpp;
        rep_t   h_rep;
        rep_t   v_rep;
        color_t colorbase;
        color_t border;
        logic   blank;
        addr_t  last_start;                                     // expected first read of line 5
    } case_t;

    logic                clk;
    logic                reset_i;
    hcount_t             h_count;
    logic                mem_fetch;
    logic                mem_fetch_start;
    logic                end_of_line;
    logic                end_of_frame;
    logic                reg_wr;
    logic [`PF_REG_W-1:0] reg_num;
    word_t               reg_data;
    logic                vram_sel;
    addr_t               vram_addr;
    word_t               vram_data = '0;                        // vram model read register
    color_t              color;
    case_t               cases [NUM_CASES];
    int                  seed;
    int                  pixel_errs;
    int                  addr_errs;
    int                  other_errs;

    video_playfield u_dut (
        .clk, .reset_i, .h_count_i(h_count), .mem_fetch_i(mem_fetch),
        .mem_fetch_start_i(mem_fetch_start), .end_of_line_i(end_of_line),
        .end_of_frame_i(end_of_frame), .reg_wr_i(reg_wr), .reg_num_i(reg_num),
        .reg_data_i(reg_data), .vram_sel_o(vram_sel), .vram_addr_o(vram_addr),
        .vram_data_i(vram_data), .color_o(color)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                                  // 100 MHz
    end

    // contents of vram, known at every address
    function automatic word_t vram_word(addr_t a);
        return a ^ 16'hA5C3;
    endfunction

    always @(posedge clk) begin
        if (vram_sel) begin
            vram_data <= vram_word(vram_addr);                  // one cycle read latency
        end
    end

    // pixel i of a line before the color base
    function automatic color_t line_pixel(addr_t start, bpp_e bpp, int i);
        word_t w;
        if (bpp == BPP_8) begin
            w = vram_word(start + addr_t'(i / 2));
            return (i % 2 == 0) ? w[15:8] : w[7:0];             // high byte first
        end
        w = vram_word(start + addr_t'(i / 4));
        return {4'h0, w[15 - 4*(i % 4) -: 4]};                  // high nibble first
    endfunction

    function automatic color_t expected_color(case_t c, addr_t line_start, int h);
        int idx;
        if (c.blank || h < FIRST_PIX || h > LAST_PIX) begin
            return c.border;
        end
        idx = (h - FIRST_PIX) / (int'(c.h_rep) + 1);            // each pixel lasts r+1 cycles
        return line_pixel(line_start, c.bpp, idx) ^ c.colorbase;
    endfunction

    function automatic word_t gfx_word(case_t c);
        word_t w;
        w = '0;
        w[`PF_GFX_BLANK_BIT]     = c.blank;
        w[`PF_GFX_BPP_BIT]       = c.bpp;
        w[`PF_GFX_HREP_LSB +: 2] = c.h_rep;
        w[`PF_GFX_VREP_LSB +: 2] = c.v_rep;
        return w;
    endfunction

    task automatic fill_cases();
        color_t rnd_base;
        color_t rnd_border;
        rnd_base   = color_t'($random(seed));
        rnd_border = color_t'($random(seed));
        //            start     len     bpp    hr    vr    base   border blank  line 5
        cases[0] = '{16'h0100, 16'd40, BPP_8, 2'd0, 2'd0, 8'h00, 8'h11, 1'b0, 16'h01C8};
        cases[1] = '{16'h1234, 16'd20, BPP_4, 2'd1, 2'd1, 8'h5A, 8'h22, 1'b0, 16'h125C};
        cases[2] = '{16'hFFF0, 16'd64, BPP_8, 2'd2, 2'd2, 8'hC3, 8'h33, 1'b0,
                     16'h0030};                                 // wraps across the top
        cases[3] = '{16'h2000, 16'd8,  BPP_8, 2'd0, 2'd0, 8'h77, 8'h55, 1'b1, 16'h0000};
        cases[4] = '{16'h0800, 16'd10, BPP_4, 2'd3, 2'd3, 8'h0F, 8'h44, 1'b0, 16'h080A};
        cases[5] = '{16'h3000, 16'd3,  BPP_4, 2'd0, 2'd0, rnd_base, rnd_border, 1'b0,
                     16'h300F};                                 // random base and border
    endtask

    task automatic write_reg(logic [`PF_REG_W-1:0] num, word_t data);
        @(posedge clk);
        #1;
        reg_wr   = 1'b1;
        reg_num  = num;
        reg_data = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic restart_frame();
        @(posedge clk);
        #1;
        end_of_frame = 1'b1;                                    // reload start address
        @(posedge clk);
        #1;
        end_of_frame = 1'b0;
    endtask

    // one scanline of timing, checking color_o and the vram reads each cycle
    task automatic run_line(case_t c, int line);
        addr_t  exp_start;                                      // first word of this line
        addr_t  exp_addr;                                       // next select address
        addr_t  first_addr;
        logic   seen_sel;
        color_t exp_color;
        exp_start  = c.start + addr_t'(int'(c.len) * (line / (int'(c.v_rep) + 1)));
        exp_addr   = exp_start;
        first_addr = '0;
        seen_sel   = 1'b0;
        for (int h = 0; h < LINE_H; h++) begin                  // bounded by the line length
            @(posedge clk);
            #1;
            exp_color = expected_color(c, exp_start, h);
            assert (color == exp_color) else begin
                pixel_errs++;
                $display("FAILED color_o line %0d h %0d: got 0x%h, expected 0x%h",
                         line, h, color, exp_color);
            end
            if (vram_sel) begin
                assert (!c.blank) else begin
                    other_errs++;
                    $display("VRAM read at h %0d of line %0d while the plane is blanked",
                             h, line);
                end
                assert (c.blank || vram_addr == exp_addr) else begin
                    addr_errs++;
                    $display("FAILED vram_addr_o line %0d h %0d: got 0x%h, expected 0x%h",
                             line, h, vram_addr, exp_addr);
                end
                if (!seen_sel) begin
                    first_addr = vram_addr;
                end
                exp_addr = exp_addr + 1'b1;                     // reads run on through the line
                seen_sel = 1'b1;
            end
            h_count         = hcount_t'(h);
            mem_fetch       = (h >= FETCH_START) && (h <= FETCH_STOP);
            mem_fetch_start = (h == FETCH_START);
            end_of_line     = (h == LINE_H - 1);
        end
        assert (c.blank || seen_sel) else begin
            other_errs++;
            $display("no VRAM read seen during line %0d", line);
        end
        if (line == LINES - 1 && !c.blank) begin
            assert (first_addr == c.last_start) else begin
                addr_errs++;
                $display("FAILED vram_addr_o first of line %0d: got 0x%h, expected 0x%h",
                         line, first_addr, c.last_start);
            end
        end
        @(posedge clk);
        #1;
        end_of_line = 1'b0;
        h_count     = '0;
    endtask

    initial begin
        seed            = 54285;
        pixel_errs      = 0;
        addr_errs       = 0;
        other_errs      = 0;
        reset_i         = 1'b1;
        h_count         = '0;
        mem_fetch       = 1'b0;
        mem_fetch_start = 1'b0;
        end_of_line     = 1'b0;
        end_of_frame    = 1'b0;
        reg_wr          = 1'b0;
        reg_num         = '0;
        reg_data        = '0;
        fill_cases();
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(posedge clk);
        #1;
        assert (vram_sel == 1'b0) else begin
            addr_errs++;
            $display("FAILED vram_sel_o after reset: got 0x%h, expected 0x0", vram_sel);
        end
        assert (color == '0) else begin
            pixel_errs++;
            $display("FAILED color_o after reset: got 0x%h, expected 0x00", color);
        end
        for (int k = 0; k < NUM_CASES; k++) begin
            write_reg(`PF_REG_START, cases[k].start);
            write_reg(`PF_REG_LINE_LEN, cases[k].len);
            write_reg(`PF_REG_GFX_CTRL, gfx_word(cases[k]));
            write_reg(`PF_REG_COLORBASE, word_t'(cases[k].colorbase));
            write_reg(`PF_REG_BORDER, word_t'(cases[k].border));
            restart_frame();
            for (int n = 0; n < LINES; n++) begin
                run_line(cases[k], n);
            end
        end
        $display("errors: pixel %0d, address %0d, other %0d", pixel_errs, addr_errs,
                 other_errs);
        if (pixel_errs + addr_errs + other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #1_000_000;                                             // whole run is about 330 us
        $display("watchdog expired before the test sequence completed");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* video_playfield.f */
+incdir+include
rtl/pf_pkg.sv
rtl/pf_regs.sv
rtl/pf_line_addr.sv
rtl/pf_fetch.sv
rtl/pf_pixel_buf.sv
rtl/pf_scanout.sv
rtl/video_playfield.sv
verification/video_playfield_sva.sv
verification/tb_video_playfield.sv

/* Makefile */
TOP := tb_video_playfield

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f video_playfield.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f video_playfield.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
